// ==== verilog.f ====
+incdir+.
cam_cfg_pkg.sv
sccb_cmd_if.sv
cam_reg_table.sv
cam_config_seq.sv
sccb_write_engine.sv
cam_reg_config.sv
tb_cam_reg_config.sv

// ==== Makefile ====
# Verilator flow for the camera register configuration block

TOP = tb_cam_reg_config

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_cam_reg_config.sv ====
//**********************************************************
// Testbench for the camera register configuration top
//   Clock, reset and initial_en stimulus
//   SCCB slave model on a wired-AND SDA line
//   Reference table, compare tasks and scenarios
//**********************************************************

`timescale 1ns/1ps

`include "cam_cfg_macros.svh"

module tb_cam_reg_config;

  import cam_cfg_pkg::*;

  localparam int XFER_TIMEOUT = 2000;     // Cycles per transfer wait
  localparam int DONE_TIMEOUT = 200;      // Cycles from last stop to done
  localparam int HOLD_CYCLES  = 1000;     // initial_en low for longer than one transfer

  logic clk_24m;
  logic cam_rstn;
  logic initial_en;
  logic reg_conf_done;
  logic i2c_sclk;
  logic i2c_sdat_oe;
  logic i2c_sdat_in;

  // Slave model state
  logic        ack_pull;                  // Slave pulls SDA low
  logic        bus_sda;                   // Wired-AND line level
  logic        prev_scl;
  logic        prev_sda;
  logic        in_xfer;
  logic [31:0] shreg;                     // Bytes shifted in, MSB first
  int          bit_cnt;
  int          byte_cnt;
  int          cur_id;                    // Id of transfer on the bus
  int          xfer_num;                  // Start conditions seen
  int          nack_xfer;                 // Transfer id to NACK or -1
  int          nack_byte;                 // Byte of that transfer to NACK
  logic [31:0] frame_q[$];                // Completed transfers
  int          len_q[$];                  // Byte count per transfer

  cam_reg_config #(.TICK_DIV(4)) i_cam_reg_config
  (
    .clk_24m       (clk_24m),
    .cam_rstn      (cam_rstn),
    .initial_en    (initial_en),
    .reg_conf_done (reg_conf_done),
    .i2c_sclk      (i2c_sclk),
    .i2c_sdat_oe   (i2c_sdat_oe),
    .i2c_sdat_in   (i2c_sdat_in)
  );

  // Board pull-up where either side may pull low
  assign bus_sda     = ~(i2c_sdat_oe | ack_pull);
  assign i2c_sdat_in = bus_sda;

  initial
  begin
    clk_24m = 1'b0;
    forever #50 clk_24m = ~clk_24m;       // 100 ns period
  end

  //********************************************************
  // SCCB slave model
  //********************************************************
  initial
  begin
    ack_pull = 1'b0;
    prev_scl = 1'b1;
    prev_sda = 1'b1;
    in_xfer  = 1'b0;
    shreg    = '0;
    bit_cnt  = 0;
    byte_cnt = 0;
    cur_id   = 0;
    xfer_num = 0;
  end

  always @(posedge clk_24m)
  begin
    prev_scl <= i2c_sclk;
    prev_sda <= bus_sda;
    if (prev_scl && i2c_sclk && prev_sda && !bus_sda)
    begin
      in_xfer  <= 1'b1;                   // Start condition
      bit_cnt  <= 0;
      byte_cnt <= 0;
      cur_id   <= xfer_num;
      xfer_num <= xfer_num + 1;
    end
    else if (prev_scl && i2c_sclk && !prev_sda && bus_sda)
    begin
      if (in_xfer)
      begin
        frame_q.push_back(shreg);         // Stop condition ends transfer
        len_q.push_back(byte_cnt);
      end
      in_xfer <= 1'b0;
    end
    else if (in_xfer && byte_cnt < 4)
    begin
      if (!prev_scl && i2c_sclk)
      begin
        if (bit_cnt < 8)
          shreg <= {shreg[30:0], bus_sda};
        bit_cnt <= bit_cnt + 1;           // Ninth rise is the ACK clock
      end
      else if (prev_scl && !i2c_sclk)
      begin
        if (bit_cnt == 8)
          ack_pull <= !(cur_id == nack_xfer && byte_cnt == nack_byte);
        else if (bit_cnt == 9)
        begin
          ack_pull <= 1'b0;               // Release after ACK clock
          bit_cnt  <= 0;
          byte_cnt <= byte_cnt + 1;
        end
      end
    end
  end

  //********************************************************
  // Reference and compare tasks
  //********************************************************
  function automatic cam_reg_entry_t exp_entry(input int idx);
    case (idx)
      0       : return 24'h310311;
      1       : return 24'h300882;
      2       : return 24'h300842;
      3       : return 24'h310303;
      4       : return 24'h3017ff;
      5       : return 24'h3018ff;
      6       : return 24'h30341a;
      7       : return 24'h303713;
      8       : return 24'h310801;
      9       : return 24'h380000;
      10      : return 24'h380100;
      11      : return 24'h380200;
      12      : return 24'h3803fa;
      13      : return 24'h38040a;
      14      : return 24'h38053f;
      15      : return 24'h380606;
      16      : return 24'h3807a9;
      17      : return 24'h380805;
      18      : return 24'h380900;
      19      : return 24'h380a02;
      20      : return 24'h380bd0;
      21      : return 24'h380c07;
      22      : return 24'h380d64;
      23      : return 24'h380e02;
      24      : return 24'h380fe4;
      default : return '0;
    endcase
  endfunction

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0d ns: %s got %02h expected %02h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_entry(input cam_reg_entry_t got, input cam_reg_entry_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0d ns: %s got %06h expected %06h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_done(input logic exp, input string what);
    if (reg_conf_done !== exp)
    begin
      $display("CHECK FAILED at %0d ns: reg_conf_done %b expected %b, %s",
               $time, reg_conf_done, exp, what);
      end_with_failure();
    end
  endtask

  //********************************************************
  // Stimulus and wait helpers
  //********************************************************
  task automatic apply_reset();
    @(posedge clk_24m);
    cam_rstn   <= 1'b0;
    initial_en <= 1'b0;
    repeat (8) @(posedge clk_24m);        // Reset held 8 cycles
    cam_rstn <= 1'b1;
    frame_q.delete();
    len_q.delete();
  endtask

  task automatic set_enable(input logic val);
    @(posedge clk_24m);
    initial_en <= val;
  endtask

  task automatic wait_xfer(output logic [31:0] frame);
    int n;
    int len;
    n = 0;
    while (frame_q.size() == 0)
    begin
      @(negedge clk_24m);                 // Sample away from drive edge
      n++;
      if (n > XFER_TIMEOUT)
      begin
        $display("Timed out waiting for an SCCB transfer to complete");
        end_with_failure();
      end
    end
    frame = frame_q.pop_front();
    len   = len_q.pop_front();
    if (len != 4)
    begin
      $display("Transfer ended after %0d bytes instead of 4", len);
      end_with_failure();
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (reg_conf_done !== 1'b1)
    begin
      @(negedge clk_24m);
      n++;
      if (n > DONE_TIMEOUT)
      begin
        $display("Timed out waiting for reg_conf_done after the last transfer");
        end_with_failure();
      end
    end
  endtask

  // Bus stays idle while done holds exp_done
  task automatic check_quiet(input int cycles, input logic exp_done);
    int start_num;
    start_num = xfer_num;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge clk_24m);
      check_done(exp_done, "during idle window");
      if (xfer_num != start_num)
      begin
        $display("Start condition seen while the bus should stay idle");
        end_with_failure();
      end
    end
  endtask

  // Whole table in order with one repeat at nack_idx if >= 0
  task automatic run_sequence(input int nack_idx);
    logic [31:0] frame;
    int          idx;
    logic        retried;
    idx     = 0;
    retried = 1'b0;
    while (idx < `CAM_REG_COUNT)
    begin
      wait_xfer(frame);
      check_byte(frame[31:24], `CAM_SCCB_DEV_ADDR, "device address");
      check_entry(cam_reg_entry_t'(frame[23:0]), exp_entry(idx),
                  $sformatf("entry %0d", idx));
      check_done(1'b0, $sformatf("after entry %0d", idx));
      if (idx == nack_idx && !retried)
        retried = 1'b1;                   // Same entry comes again
      else
        idx++;
    end
    wait_done();
    check_done(1'b1, "after last entry");
  endtask

  //********************************************************
  // Scenarios
  //********************************************************
  initial
  begin
    int nack_idx;
    int drop_after;
    int extra;
    logic [31:0] frame;
    cam_rstn   = 1'b0;
    initial_en = 1'b0;
    nack_xfer  = -1;
    nack_byte  = 0;
    void'($urandom(32'h5329_99d4));

    // Bus stays idle while enable held low
    apply_reset();
    check_quiet(3000, 1'b0);

    // Clean run then done holds with no new start
    apply_reset();
    set_enable(1'b1);
    run_sequence(-1);
    check_quiet(3000, 1'b1);

    // One NACK on a random byte of a random entry
    apply_reset();
    nack_idx  = $urandom_range(`CAM_REG_COUNT - 1, 0);
    nack_byte = $urandom_range(3, 0);
    nack_xfer = xfer_num + nack_idx;
    set_enable(1'b1);
    run_sequence(nack_idx);
    nack_xfer = -1;

    // Drop initial_en mid sequence and restart from entry 0
    apply_reset();
    drop_after = $urandom_range(20, 2);
    extra      = $urandom_range(400, 0);
    set_enable(1'b1);
    for (int i = 0; i < drop_after; i++)
    begin
      wait_xfer(frame);
      check_entry(cam_reg_entry_t'(frame[23:0]), exp_entry(i), $sformatf("entry %0d", i));
    end
    repeat (extra) @(posedge clk_24m);
    set_enable(1'b0);
    repeat (2) @(negedge clk_24m);
    for (int n = 0; n < HOLD_CYCLES; n++)
    begin
      @(negedge clk_24m);
      check_done(1'b0, "while initial_en low");
    end
    frame_q.delete();                     // Drop the transfer cut short
    len_q.delete();
    set_enable(1'b1);
    run_sequence(-1);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== cam_reg_config.sv ====
//**********************************************************
// Camera register configuration top level
//   Register table, sequencer and SCCB write engine
//   SDA split into pull-low enable and sensed input
//**********************************************************

`timescale 1ns/1ps

`include "cam_cfg_macros.svh"

module cam_reg_config
#(
  parameter int TICK_DIV = `CAM_TICK_DIV_DEFAULT    // clk_24m cycles per quarter bit
)
(
  input  logic clk_24m,
  input  logic cam_rstn,
  input  logic initial_en,                // Start or restart configuration
  output logic reg_conf_done,             // All writes acknowledged
  output logic i2c_sclk,
  output logic i2c_sdat_oe,               // Drive SDA low
  input  logic i2c_sdat_in                // Wired SDA level
);

  import cam_cfg_pkg::*;

  cam_reg_idx_t   reg_idx;                // Sequencer to table
  cam_reg_entry_t reg_entry;              // Table to sequencer

  sccb_cmd_if cmd_if ();                  // Sequencer to engine

  //********************************************************
  // Instances
  //********************************************************
  cam_reg_table i_cam_reg_table
  (
    .reg_idx       (reg_idx),
    .reg_entry     (reg_entry)
  );

  cam_config_seq i_cam_config_seq
  (
    .clk_24m       (clk_24m),
    .cam_rstn      (cam_rstn),
    .initial_en    (initial_en),
    .reg_idx       (reg_idx),
    .reg_entry     (reg_entry),
    .cmd           (cmd_if.seq_mp),
    .reg_conf_done (reg_conf_done)
  );

  sccb_write_engine #(.TICK_DIV(TICK_DIV)) i_sccb_write_engine
  (
    .clk_24m       (clk_24m),
    .cam_rstn      (cam_rstn),
    .cmd           (cmd_if.eng_mp),
    .i2c_sclk      (i2c_sclk),
    .i2c_sdat_oe   (i2c_sdat_oe),
    .i2c_sdat_in   (i2c_sdat_in)
  );

endmodule

// ==== sccb_write_engine.sv ====
//**********************************************************
// SCCB write engine
//   Quarter-bit tick from a clk_24m divider
//   Start, device address, three entry bytes, stop
//   ACK sampled per byte, NACK reported with the credit
//**********************************************************

`timescale 1ns/1ps

`include "cam_cfg_macros.svh"

module sccb_write_engine
#(
  parameter int TICK_DIV = `CAM_TICK_DIV_DEFAULT    // clk_24m cycles per quarter bit
)
(
  input  logic       clk_24m,
  input  logic       cam_rstn,
  sccb_cmd_if.eng_mp cmd,                           // Commands in, credits out
  output logic       i2c_sclk,                      // Bus clock
  output logic       i2c_sdat_oe,                   // High pulls SDA low
  input  logic       i2c_sdat_in                    // Sensed SDA level
);

  import cam_cfg_pkg::*;

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;              // Tick divider
  logic             tick;                 // Quarter-bit strobe
  sccb_phase_e      phase;
  logic [1:0]       qtr;                  // Quarter within phase
  logic [2:0]       bit_cnt;              // Bit within byte
  logic [1:0]       byte_cnt;             // Byte within transfer
  logic [31:0]      frame;                // Address plus entry, MSB out first
  logic             pend;                 // Command taken, not yet started
  logic             nack_q;               // Sticky NACK of this transfer
  logic             ret_q;                // Credit pulse

  assign cmd.credit_return = ret_q;
  assign cmd.cmd_nack      = nack_q;

  //********************************************************
  // Tick generator
  //********************************************************
  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge clk_24m or negedge cam_rstn)
  begin
    if (!cam_rstn)
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  //********************************************************
  // Transfer shift register
  //********************************************************
  always_ff @(posedge clk_24m)
  begin
    if (cmd.cmd_valid)
      frame <= {`CAM_SCCB_DEV_ADDR, cmd.cmd_entry};   // Load whole transfer
    else if (tick && phase == SCCB_BIT && qtr == 2'd3)
      frame <= {frame[30:0], 1'b0};                   // Next bit after SCL falls
  end

  //********************************************************
  // Phase FSM
  //********************************************************
  always_ff @(posedge clk_24m or negedge cam_rstn)
  begin
    if (!cam_rstn)
    begin
      phase    <= SCCB_IDLE;
      qtr      <= 2'd0;
      bit_cnt  <= 3'd0;
      byte_cnt <= 2'd0;
      pend     <= 1'b0;
      nack_q   <= 1'b0;
      ret_q    <= 1'b0;
    end
    else
    begin
      ret_q <= 1'b0;
      if (cmd.cmd_valid)
        pend <= 1'b1;                     // Always room, credit guaranteed
      if (tick)
      begin
        qtr <= qtr + 2'd1;                // Wraps every four ticks
        case (phase)
          SCCB_IDLE  :
          begin
            qtr <= 2'd0;
            if (pend)
            begin
              pend   <= 1'b0;
              nack_q <= 1'b0;             // Fresh status per transfer
              phase  <= SCCB_START;
            end
          end
          SCCB_START :
            if (qtr == 2'd3)
            begin
              bit_cnt  <= 3'd0;
              byte_cnt <= 2'd0;
              phase    <= SCCB_BIT;
            end
          SCCB_BIT   :
            if (qtr == 2'd3)
            begin
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7)
                phase <= SCCB_ACK;
            end
          SCCB_ACK   :
          begin
            if (qtr == 2'd1 && i2c_sdat_in)
              nack_q <= 1'b1;             // Sampled mid SCL high
            if (qtr == 2'd3)
            begin
              byte_cnt <= byte_cnt + 2'd1;
              phase    <= (byte_cnt == 2'd3) ? SCCB_STOP : SCCB_BIT;
            end
          end
          SCCB_STOP  :
            if (qtr == 2'd3)
            begin
              ret_q <= 1'b1;              // Credit one cycle after stop tick
              phase <= SCCB_IDLE;
            end
          default    : phase <= SCCB_IDLE;
        endcase
      end
    end
  end

  //********************************************************
  // Bus pin decode
  //********************************************************
  // SCL high in quarters 1 and 2 of each bit, SDA moves in quarter 0
  always_comb
  begin
    i2c_sclk    = 1'b1;                   // Idle bus released
    i2c_sdat_oe = 1'b0;
    case (phase)
      SCCB_START :
      begin
        i2c_sclk    = (qtr != 2'd3);
        i2c_sdat_oe = (qtr != 2'd0);      // SDA falls under high SCL
      end
      SCCB_BIT   :
      begin
        i2c_sclk    = (qtr == 2'd1) || (qtr == 2'd2);
        i2c_sdat_oe = ~frame[31];
      end
      SCCB_ACK   : i2c_sclk = (qtr == 2'd1) || (qtr == 2'd2);
      SCCB_STOP  :
      begin
        i2c_sclk    = (qtr != 2'd0);
        i2c_sdat_oe = (qtr < 2'd2);       // SDA rises under high SCL
      end
      default    : ;
    endcase
  end

  //********************************************************
  // Checks
  //********************************************************
  // Sequencer credit keeps commands away from a busy engine
  a_no_cmd_when_busy : assert property (@(posedge clk_24m) disable iff (!cam_rstn)
    cmd.cmd_valid |-> (phase == SCCB_IDLE && !pend));

endmodule

// ==== cam_config_seq.sv ====
//**********************************************************
// Configuration sequencer
//   Walks the register table one write at a time
//   Holds the command credit, resends an entry on NACK
//   Raises reg_conf_done after the last good write
//**********************************************************

`timescale 1ns/1ps

`include "cam_cfg_macros.svh"

module cam_config_seq
(
  input  logic                        clk_24m,
  input  logic                        cam_rstn,
  input  logic                        initial_en,     // Run enable, low restarts
  output cam_cfg_pkg::cam_reg_idx_t   reg_idx,        // Table entry select
  input  cam_cfg_pkg::cam_reg_entry_t reg_entry,      // Entry at reg_idx
  sccb_cmd_if.seq_mp                  cmd,            // Command path to engine
  output logic                        reg_conf_done   // Whole table written
);

  import cam_cfg_pkg::*;

  localparam int           CRED_W   = $clog2(`CAM_SCCB_CREDITS + 1);
  localparam cam_reg_idx_t LAST_IDX = cam_reg_idx_t'(`CAM_REG_COUNT - 1);

  cfg_state_e        state;
  logic              cmd_valid_q;         // Registered strobe
  logic [CRED_W-1:0] credit_cnt;          // Credits held

  assign cmd.cmd_valid = cmd_valid_q;
  assign cmd.cmd_entry = reg_entry;       // Stable while in CFG_WAIT

  //********************************************************
  // Credit counter
  //********************************************************
  // Runs apart from the FSM so a credit returning after a
  // restart is still taken back
  always_ff @(posedge clk_24m or negedge cam_rstn)
  begin
    if (!cam_rstn)
      credit_cnt <= CRED_W'(`CAM_SCCB_CREDITS);
    else
      credit_cnt <= credit_cnt + CRED_W'(cmd.credit_return) - CRED_W'(cmd_valid_q);
  end

  //********************************************************
  // Sequencer FSM
  //********************************************************
  always_ff @(posedge clk_24m or negedge cam_rstn)
  begin
    if (!cam_rstn)
    begin
      state         <= CFG_IDLE;
      reg_idx       <= '0;
      cmd_valid_q   <= 1'b0;
      reg_conf_done <= 1'b0;
    end
    else if (!initial_en)
    begin
      state         <= CFG_IDLE;          // Back to entry 0
      reg_idx       <= '0;
      cmd_valid_q   <= 1'b0;
      reg_conf_done <= 1'b0;
    end
    else
    begin
      cmd_valid_q <= 1'b0;                // Strobe lasts one cycle
      case (state)
        CFG_IDLE  : state <= CFG_ISSUE;
        CFG_ISSUE :
          if (credit_cnt != '0)
          begin
            cmd_valid_q <= 1'b1;          // Credit spent with the strobe
            state       <= CFG_WAIT;
          end
        CFG_WAIT  :
          if (cmd.credit_return)
          begin
            if (cmd.cmd_nack)
              state <= CFG_ISSUE;         // Resend same entry
            else if (reg_idx == LAST_IDX)
            begin
              reg_conf_done <= 1'b1;
              state         <= CFG_DONE;
            end
            else
              state <= CFG_NEXT;
          end
        CFG_NEXT  :
        begin
          reg_idx <= reg_idx + 1'b1;
          state   <= CFG_ISSUE;
        end
        CFG_DONE  : state <= CFG_DONE;    // Hold until initial_en drops
        default   : state <= CFG_IDLE;
      endcase
    end
  end

  //********************************************************
  // Checks
  //********************************************************
  a_issue_needs_credit : assert property (@(posedge clk_24m) disable iff (!cam_rstn)
    cmd_valid_q |-> credit_cnt != '0);

  // Engine must not hand back more credits than it was given
  a_credit_bound : assert property (@(posedge clk_24m) disable iff (!cam_rstn)
    cmd.credit_return |-> credit_cnt < CRED_W'(`CAM_SCCB_CREDITS));

endmodule

// ==== cam_reg_table.sv ====
//**********************************************************
// Sensor register write table, combinational lookup
//   Entries 0..8   clocks, reset, PLL, pad enables
//   Entries 9..24  1280x720 DVP output window
//**********************************************************

`timescale 1ns/1ps

module cam_reg_table
(
  input  cam_cfg_pkg::cam_reg_idx_t   reg_idx,      // Entry select
  output cam_cfg_pkg::cam_reg_entry_t reg_entry     // {reg_addr, reg_val}
);

  //********************************************************
  // Table body
  //********************************************************
  always_comb
  begin
    case (reg_idx)
      // Clock and power setup
      5'd0    : reg_entry = 24'h310311;    // Sysclk taken from pad
      5'd1    : reg_entry = 24'h300882;    // Soft reset
      5'd2    : reg_entry = 24'h300842;    // Soft power down
      5'd3    : reg_entry = 24'h310303;    // Sysclk from PLL
      5'd4    : reg_entry = 24'h3017ff;    // Sync, PCLK, D[9:6] pads out
      5'd5    : reg_entry = 24'h3018ff;    // D[5:0], GPIO pads out
      5'd6    : reg_entry = 24'h30341a;    // 10-bit MIPI mode
      5'd7    : reg_entry = 24'h303713;    // PLL root and pre divider
      5'd8    : reg_entry = 24'h310801;    // PCLK and SCLK root dividers
      // Window start
      5'd9    : reg_entry = 24'h380000;    // X start high
      5'd10   : reg_entry = 24'h380100;    // X start low
      5'd11   : reg_entry = 24'h380200;    // Y start high
      5'd12   : reg_entry = 24'h3803fa;    // Y start low
      // Window end
      5'd13   : reg_entry = 24'h38040a;    // X end high
      5'd14   : reg_entry = 24'h38053f;    // X end low
      5'd15   : reg_entry = 24'h380606;    // Y end high
      5'd16   : reg_entry = 24'h3807a9;    // Y end low
      // Output size 1280x720
      5'd17   : reg_entry = 24'h380805;    // Width high
      5'd18   : reg_entry = 24'h380900;    // Width low
      5'd19   : reg_entry = 24'h380a02;    // Height high
      5'd20   : reg_entry = 24'h380bd0;    // Height low
      // Total frame timing
      5'd21   : reg_entry = 24'h380c07;    // HTS high
      5'd22   : reg_entry = 24'h380d64;    // HTS low
      5'd23   : reg_entry = 24'h380e02;    // VTS high
      5'd24   : reg_entry = 24'h380fe4;    // VTS low
      default : reg_entry = '0;            // Outside table
    endcase
  end

endmodule

// ==== sccb_cmd_if.sv ====
//**********************************************************
// Command path between the config sequencer and the
// SCCB write engine, credit based with returned status
//**********************************************************

`timescale 1ns/1ps

interface sccb_cmd_if;

  import cam_cfg_pkg::*;

  logic           cmd_valid;               // One-cycle command strobe
  cam_reg_entry_t cmd_entry;               // Register write to send
  logic           credit_return;           // Pulse when a transfer ends
  logic           cmd_nack;                // Some byte was not acknowledged

  // Sequencer side
  modport seq_mp (
    output cmd_valid,
    output cmd_entry,
    input  credit_return,
    input  cmd_nack
  );

  // Engine side
  modport eng_mp (
    input  cmd_valid,
    input  cmd_entry,
    output credit_return,
    output cmd_nack
  );

endinterface

// ==== cam_cfg_pkg.sv ====
//**********************************************************
// Types for the sensor configuration block
//   Table index and register write entry
//   Sequencer states and bus engine phases
//**********************************************************

`include "cam_cfg_macros.svh"

package cam_cfg_pkg;

  // Index wide enough to address every table entry
  typedef logic [$clog2(`CAM_REG_COUNT)-1:0] cam_reg_idx_t;

  // One sensor register write, sent high byte first
  typedef struct packed {
    logic [15:0] reg_addr;                 // 16-bit sensor register address
    logic [7:0]  reg_val;                  // Value byte
  } cam_reg_entry_t;

  // Sequencer states
  typedef enum logic [2:0] {
    CFG_IDLE,                              // Held while initial_en low
    CFG_ISSUE,                             // Waiting for a credit to send
    CFG_WAIT,                              // Transfer in flight
    CFG_NEXT,                              // Step to next entry
    CFG_DONE                               // Whole table written
  } cfg_state_e;

  // Bus engine phases, four ticks each
  typedef enum logic [2:0] {
    SCCB_IDLE,                             // Bus released
    SCCB_START,                            // SDA falls while SCL high
    SCCB_BIT,                              // One data bit, MSB first
    SCCB_ACK,                              // SDA released for slave ACK
    SCCB_STOP                              // SDA rises while SCL high
  } sccb_phase_e;

endpackage

// ==== cam_cfg_macros.svh ====
//**********************************************************
// Shared constants for the sensor configuration block
//   SCCB write address of the sensor
//   Register table length
//   Default quarter-bit tick divider
//   Command credits between sequencer and bus engine
//**********************************************************

`ifndef CAM_CFG_MACROS_SVH
`define CAM_CFG_MACROS_SVH

// 8-bit write address, R/W bit already zero
`define CAM_SCCB_DEV_ADDR 8'h78

// Entries in the register write table
`define CAM_REG_COUNT 25

// clk_24m cycles per quarter bit, 5 kHz bit rate at 24 MHz
`define CAM_TICK_DIV_DEFAULT 1200

// Commands the bus engine can hold at once
`define CAM_SCCB_CREDITS 1

`endif
